//--- rtl/uart_cfg_pkg.sv
// UART line configuration types used by the receiver frame logic and its users
`default_nettype none

package uart_cfg_pkg;

  // --------------------------------------------------
  // Line format fields
  // --------------------------------------------------

  // Number of data bits in one frame
  // The encoding plus 5 gives the bit count
  typedef enum logic [1:0] {
    DW_5BIT = 2'd0,
    DW_6BIT = 2'd1,
    DW_7BIT = 2'd2,
    DW_8BIT = 2'd3
  } data_width_e;

  // Parity rule applied to the data bits
  typedef enum logic [1:0] {
    PAR_NONE = 2'd0,
    PAR_EVEN = 2'd1,
    PAR_ODD  = 2'd2
  } parity_mode_e;

  // Number of stop bits closing the frame
  typedef enum logic {
    SB_1BIT = 1'b0,
    SB_2BIT = 1'b1
  } stop_bits_e;

  // Complete line format of 5 bits that stays static during a frame
  typedef struct packed {
    data_width_e  data_width;
    parity_mode_e parity;
    stop_bits_e   stop_bits;
  } line_cfg_t;

endpackage

`default_nettype wire

//--- rtl/uart_rx_pkg.sv
// UART receiver datapath types, FIFO geometry and the stored word layout
`default_nettype none

package uart_rx_pkg;

  // --------------------------------------------------
  // Datapath widths
  // --------------------------------------------------

  // Received data byte that is right-justified with unused high bits at zero
  typedef logic [7:0] rx_data_t;

  // Oversampling tick index inside one bit period
  typedef logic [3:0] os_count_t;

  // Index of the data bit being sampled
  typedef logic [2:0] bit_count_t;

  // --------------------------------------------------
  // Bit timing
  // --------------------------------------------------

  // Tick that lands in the middle of the start bit
  localparam os_count_t OS_MID = 4'd7;

  // Tick that closes one full bit period
  // From the middle of the start bit this keeps every sample mid-bit
  localparam os_count_t OS_LAST = 4'd15;

  // --------------------------------------------------
  // Receive FIFO
  // --------------------------------------------------

  // Number of stored words
  localparam int FIFO_DEPTH = 16;

  // Occupancy from 0 up to and including FIFO_DEPTH
  typedef logic [4:0] fifo_count_t;

  // Stream mode interrupt level where zero means interrupt at full
  typedef logic [4:0] threshold_t;

  // One received frame of 11 bits with its error flags
  typedef struct packed {
    rx_data_t data;
    logic     frame_err;
    logic     parity_err;
    logic     overrun;
  } rx_word_t;

endpackage

`default_nettype wire

//--- rtl/uart_rx_frame.sv
// UART receive frame engine with start detection, mid-bit sampling and error flags
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frame (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   ov_tick_i,
  input  logic                   rx_i,
  input  uart_cfg_pkg::line_cfg_t cfg_i,
  input  logic                   irq_pending_i,
  input  logic                   fifo_full_i,
  output logic                   word_valid_o,
  output uart_rx_pkg::rx_word_t  word_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_e;

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------

  rx_state_e               state_q;
  uart_rx_pkg::os_count_t  os_cnt_q;
  uart_rx_pkg::bit_count_t bit_cnt_q;
  // Set once the first of two stop bits has been sampled
  logic                    stop_cnt_q;
  logic                    valid_q;
  // A finished frame was dropped because the FIFO was full
  logic                    lost_q;
  // An unserviced interrupt was seen while this frame was on the line
  logic                    pend_seen_q;

  // Payload registers
  uart_rx_pkg::rx_data_t   shift_q;
  logic                    par_acc_q;
  logic                    frame_err_q;
  logic                    par_err_q;
  uart_rx_pkg::rx_word_t   word_q;

  logic                    mid_tick;
  logic                    bit_tick;
  uart_rx_pkg::bit_count_t last_bit_idx;
  logic                    last_data;
  logic                    last_stop;
  logic [1:0]              justify;

  // Sampling points inside the bit period
  assign mid_tick = ov_tick_i && (os_cnt_q == uart_rx_pkg::OS_MID);
  assign bit_tick = ov_tick_i && (os_cnt_q == uart_rx_pkg::OS_LAST);

  // Width code 0 to 3 maps onto last data bit index 4 to 7
  assign last_bit_idx = {1'b1, cfg_i.data_width};
  assign last_data    = (bit_cnt_q == last_bit_idx);
  assign last_stop    = (cfg_i.stop_bits == uart_cfg_pkg::SB_1BIT) || stop_cnt_q;

  // Bits enter at the MSB, so short words sit high and are shifted down
  assign justify = 2'd3 - cfg_i.data_width;

  // --------------------------------------------------
  // Frame FSM
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      os_cnt_q    <= '0;
      bit_cnt_q   <= '0;
      stop_cnt_q  <= 1'b0;
      valid_q     <= 1'b0;
      lost_q      <= 1'b0;
      pend_seen_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;

      // The pulse after the last stop bit tells whether the FIFO took the word
      // A stored word has already carried the loss, so the flag is cleared
      if (valid_q) begin
        lost_q <= fifo_full_i;
      end

      if ((state_q != ST_IDLE) && irq_pending_i) begin
        pend_seen_q <= 1'b1;
      end

      // Tick counter wraps from OS_LAST to zero on its own between bits
      if (ov_tick_i) begin
        os_cnt_q <= os_cnt_q + 1'b1;
      end

      case (state_q)
        ST_IDLE: begin
          os_cnt_q <= '0;
          if (!rx_i) begin
            state_q     <= ST_START;
            pend_seen_q <= 1'b0;
          end
        end

        ST_START: begin
          // A high line in the middle of the start bit was a glitch
          if (mid_tick) begin
            os_cnt_q   <= '0;
            bit_cnt_q  <= '0;
            stop_cnt_q <= 1'b0;
            state_q    <= rx_i ? ST_IDLE : ST_DATA;
          end
        end

        ST_DATA: begin
          if (bit_tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (last_data) begin
              if (cfg_i.parity == uart_cfg_pkg::PAR_NONE) begin
                state_q <= ST_STOP;
              end else begin
                state_q <= ST_PARITY;
              end
            end
          end
        end

        ST_PARITY: begin
          if (bit_tick) begin
            state_q <= ST_STOP;
          end
        end

        ST_STOP: begin
          if (bit_tick) begin
            if (last_stop) begin
              state_q <= ST_IDLE;
              valid_q <= 1'b1;
            end else begin
              stop_cnt_q <= 1'b1;
            end
          end
        end

        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Data and error flags
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    // Flags start clean at the middle of a valid start bit
    if ((state_q == ST_START) && mid_tick) begin
      par_acc_q   <= 1'b0;
      frame_err_q <= 1'b0;
      par_err_q   <= 1'b0;
    end

    // LSB arrives first, so each new bit pushes in from the top
    if ((state_q == ST_DATA) && bit_tick) begin
      shift_q   <= {rx_i, shift_q[7:1]};
      par_acc_q <= par_acc_q ^ rx_i;
    end

    // Even parity expects an even count of ones including the parity bit
    if ((state_q == ST_PARITY) && bit_tick) begin
      par_err_q <= par_acc_q ^ rx_i ^ (cfg_i.parity == uart_cfg_pkg::PAR_ODD);
    end

    // Any low stop bit marks a framing error
    if ((state_q == ST_STOP) && bit_tick) begin
      frame_err_q <= frame_err_q | !rx_i;
      if (last_stop) begin
        word_q.data       <= shift_q >> justify;
        word_q.frame_err  <= frame_err_q | !rx_i;
        word_q.parity_err <= par_err_q;
        word_q.overrun    <= pend_seen_q | lost_q;
      end
    end
  end

  assign word_valid_o = valid_q;
  assign word_o       = word_q;

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------

  // A finished word leaves only in the cycle right after the stop state
  a_valid_after_stop : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    word_valid_o |-> ($past(state_q) == ST_STOP))
    else $error("word_valid without a preceding stop state");

  // Each frame yields a single pulse
  a_valid_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    word_valid_o |=> !word_valid_o)
    else $error("word_valid high in two consecutive cycles");

endmodule

`default_nettype wire

//--- rtl/rx_fifo.sv
// Synchronous first-word-fall-through FIFO holding received UART words
`timescale 1ns/100ps
`default_nettype none

module rx_fifo (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     wr_i,
  input  uart_rx_pkg::rx_word_t    wr_word_i,
  input  logic                     rd_i,
  output uart_rx_pkg::rx_word_t    rd_word_o,
  output logic                     empty_o,
  output logic                     full_o,
  output uart_rx_pkg::fifo_count_t count_o,
  output logic                     wr_ok_o
);

  // Pointers wrap naturally since the depth is a power of two
  typedef logic [$clog2(uart_rx_pkg::FIFO_DEPTH)-1:0] ptr_t;

  uart_rx_pkg::rx_word_t    mem_q [uart_rx_pkg::FIFO_DEPTH];
  ptr_t                     wr_ptr_q;
  ptr_t                     rd_ptr_q;
  uart_rx_pkg::fifo_count_t cnt_q;
  uart_rx_pkg::fifo_count_t cnt_d;
  logic                     empty_q;
  logic                     full_q;
  logic                     rd_ok;

  // Writes to a full FIFO and reads from an empty one are dropped
  assign wr_ok_o = wr_i && !full_q;
  assign rd_ok   = rd_i && !empty_q;

  // Storage array
  always_ff @(posedge clk_i) begin
    if (wr_ok_o) begin
      mem_q[wr_ptr_q] <= wr_word_i;
    end
  end

  // Occupancy after this cycle stays unchanged on a simultaneous read and write
  always_comb begin
    cnt_d = cnt_q;
    case ({wr_ok_o, rd_ok})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // --------------------------------------------------
  // Pointers and status flags
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      empty_q  <= 1'b1;
      full_q   <= 1'b0;
    end else begin
      if (wr_ok_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q   <= cnt_d;
      empty_q <= (cnt_d == '0);
      full_q  <= (cnt_d == uart_rx_pkg::fifo_count_t'(uart_rx_pkg::FIFO_DEPTH));
    end
  end

  // Head word is always on the read port
  assign rd_word_o = mem_q[rd_ptr_q];
  assign empty_o   = empty_q;
  assign full_o    = full_q;
  assign count_o   = cnt_q;

  // Occupancy stays within the array
  a_count_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= uart_rx_pkg::fifo_count_t'(uart_rx_pkg::FIFO_DEPTH))
    else $error("FIFO count above depth");

  // Equal pointers mean an empty FIFO unless the writes have wrapped it to full
  a_empty_count : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    empty_q == ((wr_ptr_q == rd_ptr_q) && !full_q))
    else $error("FIFO empty flag disagrees with count");

endmodule

`default_nettype wire

//--- rtl/rx_ready_irq.sv
// Data-ready interrupt for the UART receiver in standard and stream modes
`timescale 1ns/100ps
`default_nettype none

module rx_ready_irq (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     stream_mode_i,
  input  uart_rx_pkg::threshold_t  threshold_i,
  input  logic                     word_stored_i,
  input  logic                     rd_i,
  input  logic                     empty_i,
  input  logic                     full_i,
  input  uart_rx_pkg::fifo_count_t count_i,
  output logic                     irq_o
);

  logic                     irq_q;
  logic                     rd_ok;
  logic                     thr_zero;
  logic                     thr_hit;
  uart_rx_pkg::fifo_count_t cnt_after;

  assign rd_ok    = rd_i && !empty_i;
  assign thr_zero = (threshold_i == '0);

  // The FIFO count lags the store by a clock, so look at the count it is heading to
  always_comb begin
    cnt_after = count_i;
    if (word_stored_i && !rd_ok) begin
      cnt_after = count_i + 1'b1;
    end else if (!word_stored_i && rd_ok) begin
      cnt_after = count_i - 1'b1;
    end
  end

  // A zero threshold means interrupt only once the FIFO fills up
  assign thr_hit = thr_zero ?
                   (cnt_after == uart_rx_pkg::fifo_count_t'(uart_rx_pkg::FIFO_DEPTH)) :
                   (cnt_after >= threshold_i);

  // --------------------------------------------------
  // Interrupt register
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_q <= 1'b0;
    end else if (stream_mode_i) begin
      // Stream mode holds the line until software drains the FIFO
      if (word_stored_i && thr_hit) begin
        irq_q <= 1'b1;
      end else if (thr_zero && full_i) begin
        irq_q <= 1'b1;
      end else if (empty_i) begin
        irq_q <= 1'b0;
      end
    end else begin
      // Standard mode flags every word and the read takes priority
      if (rd_i) begin
        irq_q <= 1'b0;
      end else if (word_stored_i) begin
        irq_q <= 1'b1;
      end
    end
  end

  assign irq_o = irq_q;

  // In standard mode a read acknowledges the pending word
  a_std_read_clears : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!stream_mode_i && rd_i && irq_q && !word_stored_i) |=> !irq_q)
    else $error("Standard mode interrupt not cleared by read");

endmodule

`default_nettype wire

//--- rtl/uart_rx_top.sv
// UART receiver top level joining the frame engine, receive FIFO and interrupt
`timescale 1ns/100ps
`default_nettype none

module uart_rx_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ov_tick_i,
  input  logic                    rx_i,
  input  uart_cfg_pkg::line_cfg_t cfg_i,
  input  logic                    stream_mode_i,
  input  uart_rx_pkg::threshold_t threshold_i,
  input  logic                    rd_i,
  output uart_rx_pkg::rx_word_t   word_o,
  output logic                    empty_o,
  output logic                    full_o,
  output logic                    irq_o
);

  // --------------------------------------------------
  // Internal connections
  // --------------------------------------------------

  logic                     word_valid;
  uart_rx_pkg::rx_word_t    frame_word;
  logic                     word_stored;
  logic                     fifo_empty;
  logic                     fifo_full;
  uart_rx_pkg::fifo_count_t fifo_count;
  logic                     irq;
  logic                     irq_pending;

  // Only a standard mode interrupt left unread counts toward overrun
  assign irq_pending = irq & !stream_mode_i;

  // Serial line to assembled words
  uart_rx_frame u_frame (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ov_tick_i     (ov_tick_i),
    .rx_i          (rx_i),
    .cfg_i         (cfg_i),
    .irq_pending_i (irq_pending),
    .fifo_full_i   (fifo_full),
    .word_valid_o  (word_valid),
    .word_o        (frame_word)
  );

  // Word buffer toward the host
  rx_fifo u_fifo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_i      (word_valid),
    .wr_word_i (frame_word),
    .rd_i      (rd_i),
    .rd_word_o (word_o),
    .empty_o   (fifo_empty),
    .full_o    (fifo_full),
    .count_o   (fifo_count),
    .wr_ok_o   (word_stored)
  );

  // Interrupt follows accepted words, reads and FIFO level
  rx_ready_irq u_irq (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stream_mode_i (stream_mode_i),
    .threshold_i   (threshold_i),
    .word_stored_i (word_stored),
    .rd_i          (rd_i),
    .empty_i       (fifo_empty),
    .full_i        (fifo_full),
    .count_i       (fifo_count),
    .irq_o         (irq)
  );

  assign empty_o = fifo_empty;
  assign full_o  = fifo_full;
  assign irq_o   = irq;

endmodule

`default_nettype wire

//--- verif/rx_checker.sv
// Checker comparing the UART receiver read port, levels and interrupt with expected values
`timescale 1ns/100ps
`default_nettype none

module rx_checker #(
  parameter int NAME_W = 24
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // DUT read port and status levels
  input  logic                  rd_i,
  input  uart_rx_pkg::rx_word_t word_i,
  input  logic                  empty_i,
  input  logic                  full_i,
  input  logic                  irq_i,
  // Expected values from the testbench
  input  logic [8*NAME_W-1:0]   name_i,
  input  logic                  push_i,
  input  uart_rx_pkg::rx_word_t push_word_i,
  input  logic                  chk_i,
  input  logic                  exp_irq_i,
  input  logic                  exp_empty_i,
  input  logic                  exp_full_i,
  output int                    errors_o,
  output int                    checks_o,
  output int                    pending_o
);

  // Words waiting to be read and the test that produced each one
  uart_rx_pkg::rx_word_t exp_q [$];
  logic [8*NAME_W-1:0]   name_q [$];
  uart_rx_pkg::rx_word_t exp_word;
  logic [8*NAME_W-1:0]   exp_name;
  int                    errors = 0;
  int                    checks = 0;
  int                    pending = 0;

  assign errors_o  = errors;
  assign checks_o  = checks;
  assign pending_o = pending;

  task automatic compare_level(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0s: %0s expected %b actual %b", name_i, what, expected, actual);
    end
  endtask

  // --------------------------------------------------
  // Read port and status comparison
  // --------------------------------------------------

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (push_i) begin
        exp_q.push_back(push_word_i);
        name_q.push_back(name_i);
        pending++;
      end

      // The head word is on the port in the same cycle as the read that pops it
      if (rd_i && !empty_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Read in %0s returned a word that was never sent", name_i);
        end else begin
          exp_word = exp_q.pop_front();
          exp_name = name_q.pop_front();
          pending--;
          checks++;
          if (word_i !== exp_word) begin
            errors++;
            $display("[ERROR] %0s: word expected data %h flags %b actual data %h flags %b",
                     exp_name, exp_word.data,
                     {exp_word.frame_err, exp_word.parity_err, exp_word.overrun},
                     word_i.data, {word_i.frame_err, word_i.parity_err, word_i.overrun});
          end
        end
      end

      // Levels are compared once the frame or the reads have settled
      if (chk_i) begin
        compare_level("irq", exp_irq_i, irq_i);
        compare_level("empty", exp_empty_i, empty_i);
        compare_level("full", exp_full_i, full_i);
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_uart_rx.sv
// Testbench for the UART receiver that sends framed serial data from a stimulus table
`timescale 1ns/100ps
`default_nettype none

module tb_uart_rx;

  localparam int NAME_W       = 24;
  localparam int CLK_PER_TICK = 4;
  localparam int CLK_PER_BIT  = 64;
  // A bad stop bit stays low past its sample point but rises before a false start is taken
  localparam int BAD_STOP_LOW = 40;
  localparam uart_cfg_pkg::parity_mode_e P_NONE = uart_cfg_pkg::PAR_NONE;
  localparam uart_cfg_pkg::parity_mode_e P_EVEN = uart_cfg_pkg::PAR_EVEN;
  localparam uart_cfg_pkg::parity_mode_e P_ODD  = uart_cfg_pkg::PAR_ODD;

  // One frame of the stimulus table
  typedef struct packed {
    uart_rx_pkg::rx_data_t   data;
    uart_cfg_pkg::line_cfg_t cfg;
    logic                    stream;
    uart_rx_pkg::threshold_t thr;
    logic                    bad_stop;
    logic                    flip_par;
    logic                    read_after;
    logic [8*NAME_W-1:0]     name;
  } stim_t;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    ov_tick_i;
  logic                    rx_i;
  uart_cfg_pkg::line_cfg_t cfg_i;
  logic                    stream_mode_i;
  uart_rx_pkg::threshold_t threshold_i;
  logic                    rd_i;
  uart_rx_pkg::rx_word_t   word_o;
  logic                    empty_o;
  logic                    full_o;
  logic                    irq_o;

  // Checker side
  logic                    push;
  uart_rx_pkg::rx_word_t   push_word;
  logic                    chk;
  logic                    exp_irq;
  logic                    exp_empty;
  logic                    exp_full;
  logic [8*NAME_W-1:0]     cur_name;
  int                      chk_errors;
  int                      chk_checks;
  int                      chk_pending;

  stim_t  table_q [$];
  integer seed;
  int     tick_div;
  int     cycle_count;
  int     cycle_limit;
  int     tb_errors;
  // Reference model of FIFO fill, interrupt and the lost-frame flag
  int     model_count;
  logic   model_irq;
  logic   model_lost;

  uart_rx_top uut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ov_tick_i     (ov_tick_i),
    .rx_i          (rx_i),
    .cfg_i         (cfg_i),
    .stream_mode_i (stream_mode_i),
    .threshold_i   (threshold_i),
    .rd_i          (rd_i),
    .word_o        (word_o),
    .empty_o       (empty_o),
    .full_o        (full_o),
    .irq_o         (irq_o)
  );

  rx_checker #(.NAME_W(NAME_W)) u_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_i        (rd_i),
    .word_i      (word_o),
    .empty_i     (empty_o),
    .full_i      (full_o),
    .irq_i       (irq_o),
    .name_i      (cur_name),
    .push_i      (push),
    .push_word_i (push_word),
    .chk_i       (chk),
    .exp_irq_i   (exp_irq),
    .exp_empty_i (exp_empty),
    .exp_full_i  (exp_full),
    .errors_o    (chk_errors),
    .checks_o    (chk_checks),
    .pending_o   (chk_pending)
  );

  // --------------------------------------------------
  // Clock, oversampling strobe and timeout
  // --------------------------------------------------

  always #4 clk_i = ~clk_i;

  // Sixteen strobes per bit at four clocks each
  always @(posedge clk_i) begin
    #1;
    tick_div = (tick_div + 1) % CLK_PER_TICK;
    ov_tick_i = (tick_div == 0);
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
      $display("Timeout after %0d cycles with the test still running", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Table helpers
  // --------------------------------------------------

  function automatic uart_cfg_pkg::line_cfg_t line_cfg(input int bits,
                                                       input uart_cfg_pkg::parity_mode_e par,
                                                       input int stops);
    uart_cfg_pkg::line_cfg_t cfg;
    cfg.data_width = uart_cfg_pkg::data_width_e'(bits - 5);
    cfg.parity     = par;
    cfg.stop_bits  = (stops == 2) ? uart_cfg_pkg::SB_2BIT : uart_cfg_pkg::SB_1BIT;
    return cfg;
  endfunction

  task automatic add_row(input uart_rx_pkg::rx_data_t data, input uart_cfg_pkg::line_cfg_t cfg,
                         input logic stream, input uart_rx_pkg::threshold_t thr,
                         input logic bad_stop, input logic flip_par, input logic read_after,
                         input logic [8*NAME_W-1:0] name);
    stim_t row;
    row.data       = data;
    row.cfg        = cfg;
    row.stream     = stream;
    row.thr        = thr;
    row.bad_stop   = bad_stop;
    row.flip_par   = flip_par;
    row.read_after = read_after;
    row.name       = name;
    table_q.push_back(row);
  endtask

  task automatic build_table();
    int i;
    // Every width and parity mode in standard mode, read back after each frame
    add_row(8'hA5, line_cfg(5, P_NONE, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w5 none");
    add_row(8'h3C, line_cfg(5, P_EVEN, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w5 even");
    add_row(8'h7E, line_cfg(5, P_ODD, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w5 odd");
    add_row(8'h96, line_cfg(6, P_NONE, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w6 none");
    add_row(8'h5B, line_cfg(6, P_EVEN, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w6 even");
    add_row(8'hC3, line_cfg(6, P_ODD, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w6 odd");
    add_row(8'h2D, line_cfg(7, P_NONE, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w7 none");
    add_row(8'hF0, line_cfg(7, P_EVEN, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w7 even");
    add_row(8'h81, line_cfg(7, P_ODD, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w7 odd");
    add_row(8'hA5, line_cfg(8, P_NONE, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w8 none");
    add_row(8'h6E, line_cfg(8, P_EVEN, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w8 even");
    add_row(8'h01, line_cfg(8, P_ODD, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "w8 odd");
    // Stop bit and parity errors
    add_row(8'h4B, line_cfg(6, P_NONE, 2), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "two stop good");
    add_row(8'hD2, line_cfg(8, P_EVEN, 2), 1'b0, 5'd0, 1'b1, 1'b0, 1'b1, "two stop bad");
    add_row(8'h35, line_cfg(7, P_ODD, 2), 1'b0, 5'd0, 1'b0, 1'b1, 1'b1, "two stop parity");
    add_row(8'h99, line_cfg(8, P_NONE, 1), 1'b0, 5'd0, 1'b1, 1'b0, 1'b1, "one stop bad");
    add_row(8'h77, line_cfg(8, P_EVEN, 1), 1'b0, 5'd0, 1'b0, 1'b1, 1'b1, "even parity flip");
    // Second frame arrives while the first interrupt is still pending
    add_row(8'h11, line_cfg(8, P_NONE, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, "std unread");
    add_row(8'h22, line_cfg(8, P_NONE, 1), 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, "std overrun");
    // Stream mode interrupt at four stored words
    add_row(8'h31, line_cfg(8, P_NONE, 1), 1'b1, 5'd4, 1'b0, 1'b0, 1'b0, "stream thr 1");
    add_row(8'h32, line_cfg(8, P_NONE, 1), 1'b1, 5'd4, 1'b0, 1'b0, 1'b0, "stream thr 2");
    add_row(8'h33, line_cfg(8, P_NONE, 1), 1'b1, 5'd4, 1'b0, 1'b0, 1'b0, "stream thr 3");
    add_row(8'h34, line_cfg(8, P_NONE, 1), 1'b1, 5'd4, 1'b0, 1'b0, 1'b1, "stream thr 4");
    // Fill the FIFO with random data, lose one frame, then store one flagged word
    for (i = 0; i < uart_rx_pkg::FIFO_DEPTH; i++) begin
      add_row(uart_rx_pkg::rx_data_t'($random(seed)), line_cfg(8, P_NONE, 1), 1'b1, 5'd0,
              1'b0, 1'b0, 1'b0, "stream full fill");
    end
    add_row(uart_rx_pkg::rx_data_t'($random(seed)), line_cfg(8, P_NONE, 1), 1'b1, 5'd0,
            1'b0, 1'b0, 1'b1, "stream full lost");
    add_row(8'h5D, line_cfg(8, P_NONE, 1), 1'b1, 5'd0, 1'b0, 1'b0, 1'b1, "stream overrun");
  endtask

  // --------------------------------------------------
  // Expected values from the frame rules
  // --------------------------------------------------

  function automatic int data_bits(input uart_cfg_pkg::line_cfg_t cfg);
    return 5 + int'(cfg.data_width);
  endfunction

  function automatic uart_rx_pkg::rx_data_t data_mask(input uart_cfg_pkg::line_cfg_t cfg);
    return uart_rx_pkg::rx_data_t'((1 << data_bits(cfg)) - 1);
  endfunction

  function automatic uart_rx_pkg::rx_word_t expected_word(input stim_t row, input logic ovr);
    uart_rx_pkg::rx_word_t word;
    word.data       = row.data & data_mask(row.cfg);
    word.frame_err  = row.bad_stop;
    word.parity_err = row.flip_par && (row.cfg.parity != P_NONE);
    word.overrun    = ovr;
    return word;
  endfunction

  // --------------------------------------------------
  // Serial driver and host side
  // --------------------------------------------------

  task automatic hold_line(input logic level, input int clocks);
    rx_i = level;
    repeat (clocks) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_frame(input stim_t row);
    int   i;
    logic par_bit;
    hold_line(1'b0, CLK_PER_BIT);
    for (i = 0; i < data_bits(row.cfg); i++) begin
      hold_line(row.data[i], CLK_PER_BIT);
    end
    if (row.cfg.parity != P_NONE) begin
      par_bit = ^(row.data & data_mask(row.cfg));
      if (row.cfg.parity == P_ODD) begin
        par_bit = !par_bit;
      end
      hold_line(par_bit ^ row.flip_par, CLK_PER_BIT);
    end
    if (row.cfg.stop_bits == uart_cfg_pkg::SB_2BIT) begin
      hold_line(1'b1, CLK_PER_BIT);
    end
    // Only the last stop bit is ever made bad
    if (row.bad_stop) begin
      hold_line(1'b0, BAD_STOP_LOW);
      hold_line(1'b1, CLK_PER_BIT - BAD_STOP_LOW);
    end else begin
      hold_line(1'b1, CLK_PER_BIT);
    end
    // One idle bit lets the word reach the FIFO and the interrupt settle
    hold_line(1'b1, CLK_PER_BIT);
  endtask

  task automatic push_expected(input uart_rx_pkg::rx_word_t word);
    push_word = word;
    push = 1'b1;
    @(posedge clk_i);
    #1;
    push = 1'b0;
  endtask

  task automatic check_status();
    exp_irq   = model_irq;
    exp_empty = (model_count == 0);
    exp_full  = (model_count == uart_rx_pkg::FIFO_DEPTH);
    chk = 1'b1;
    @(posedge clk_i);
    #1;
    chk = 1'b0;
  endtask

  // One read pulse on the host port
  task automatic read_word();
    rd_i = 1'b1;
    @(posedge clk_i);
    #1;
    rd_i = 1'b0;
  endtask

  // Back-to-back reads until the FIFO reports empty
  task automatic drain_fifo();
    while (!empty_o) begin
      rd_i = 1'b1;
      @(posedge clk_i);
      #1;
    end
    rd_i = 1'b0;
  endtask

  task automatic run_row(input stim_t row);
    logic pend;
    cfg_i         = row.cfg;
    stream_mode_i = row.stream;
    threshold_i   = row.thr;
    cur_name      = row.name;
    // Standard mode marks a frame received under an unread interrupt
    pend = model_irq && !row.stream;
    send_frame(row);
    if (model_count < uart_rx_pkg::FIFO_DEPTH) begin
      push_expected(expected_word(row, pend || model_lost));
      model_count++;
      model_lost = 1'b0;
      if (!row.stream) begin
        model_irq = 1'b1;
      end else if (row.thr == 0) begin
        model_irq = model_irq || (model_count == uart_rx_pkg::FIFO_DEPTH);
      end else begin
        model_irq = model_irq || (model_count >= row.thr);
      end
    end else begin
      model_lost = 1'b1;
    end
    check_status();
    if (row.read_after) begin
      // Stop one word short so a stream interrupt is seen held until the FIFO empties
      if (model_count > 1) begin
        while (model_count > 1) begin
          read_word();
          model_count--;
        end
        if (!row.stream) begin
          model_irq = 1'b0;
        end
        check_status();
      end
      drain_fifo();
      model_count = 0;
      model_irq   = 1'b0;
      repeat (2) begin
        @(posedge clk_i);
        #1;
      end
      check_status();
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    ov_tick_i     = 1'b0;
    rx_i          = 1'b1;
    cfg_i         = '0;
    stream_mode_i = 1'b0;
    threshold_i   = '0;
    rd_i          = 1'b0;
    push          = 1'b0;
    push_word     = '0;
    chk           = 1'b0;
    exp_irq       = 1'b0;
    exp_empty     = 1'b1;
    exp_full      = 1'b0;
    cur_name      = "reset";
    tick_div      = 0;
    cycle_count   = 0;
    cycle_limit   = 0;
    tb_errors     = 0;
    model_count   = 0;
    model_irq     = 1'b0;
    model_lost    = 1'b0;
    seed          = 32'h71b52a95;

    build_table();
    // Thirteen bit times bound the longest frame with its idle bit
    cycle_limit = table_q.size() * 13 * CLK_PER_BIT + 2000;

    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_status();

    foreach (table_q[i]) begin
      run_row(table_q[i]);
    end

    repeat (4) @(posedge clk_i);
    if (chk_pending != 0) begin
      tb_errors++;
      $display("%0d expected words were never read back", chk_pending);
    end
    $display("Checks: %0d, errors: %0d", chk_checks, chk_errors + tb_errors);
    if ((chk_errors + tb_errors) == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
rtl/uart_cfg_pkg.sv
rtl/uart_rx_pkg.sv
rtl/uart_rx_frame.sv
rtl/rx_fifo.sv
rtl/rx_ready_irq.sv
rtl/uart_rx_top.sv
verif/rx_checker.sv
verif/tb_uart_rx.sv

//--- run_sim.sh
#!/bin/sh
# Builds the UART receiver testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_uart_rx \
  -f build.f \
  -o sim_uart_rx

./obj_dir/sim_uart_rx | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
